// ==== hdl/aggregator.sv ====
`timescale 1ns/1ps

module aggregator (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [gat_pkg::NODE_CNT_W-1:0] node_cnt_i,
  output logic                           coef_pop_o,
  input  gat_pkg::score_t                coef_data_i,
  input  logic                           coef_empty_i,
  output logic [gat_pkg::NODE_IDX_W-1:0] rd_idx_o,
  input  gat_pkg::wh_t                   rd_row_i [gat_pkg::NUM_FEAT_OUT],
  output logic                           wh_release_o,
  output logic                           out_push_o,
  output gat_pkg::feat_t                 out_data_o,
  input  logic                           out_full_i
);

  gat_pkg::feat_t                     acc [gat_pkg::NUM_FEAT_OUT];
  logic                               out_phase;
  logic                               last_node;
  logic                               last_out;
  logic [gat_pkg::NODE_IDX_W-1:0]     idx;
  logic [gat_pkg::FEAT_OUT_IDX_W-1:0] out_idx;

  // Coefficient j pairs with WH row j
  assign rd_idx_o   = idx;
  assign coef_pop_o = !out_phase && !coef_empty_i;
  assign out_push_o = out_phase && !out_full_i;
  assign out_data_o = acc[out_idx];

  assign last_node = (int'(idx) == int'(node_cnt_i) - 1);
  assign last_out  = (int'(out_idx) == gat_pkg::NUM_FEAT_OUT - 1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_phase    <= 1'b0;
      idx          <= '0;
      out_idx      <= '0;
      wh_release_o <= 1'b0;
      for (int f = 0; f < gat_pkg::NUM_FEAT_OUT; f++) begin
        acc[f] <= '0;
      end
    end else begin
      wh_release_o <= 1'b0;
      if (coef_pop_o) begin
        for (int f = 0; f < gat_pkg::NUM_FEAT_OUT; f++) begin
          acc[f] <= acc[f] + gat_pkg::feat_t'(coef_data_i) * gat_pkg::feat_t'(rd_row_i[f]);
        end
        if (last_node) begin
          // All rows read, the transform may reuse the buffer
          idx          <= '0;
          out_phase    <= 1'b1;
          wh_release_o <= 1'b1;
        end else begin
          idx <= idx + 1'b1;
        end
      end
      if (out_push_o) begin
        if (last_out) begin
          out_idx   <= '0;
          out_phase <= 1'b0;
          for (int f = 0; f < gat_pkg::NUM_FEAT_OUT; f++) begin
            acc[f] <= '0;
          end
        end else begin
          out_idx <= out_idx + 1'b1;
        end
      end
    end
  end

  // Every popped coefficient belongs to a row of the current subgraph
  a_idx_in_range: assert property (
    @(posedge clk) disable iff (!rst_n) coef_pop_o |-> (int'(idx) < int'(node_cnt_i))
  );

endmodule

// ==== hdl/attn_coef.sv ====
`timescale 1ns/1ps

module attn_coef (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           wh_vld_i,
  input  logic [gat_pkg::NODE_CNT_W-1:0] node_cnt_i,
  input  gat_pkg::data_t                 a1_i [gat_pkg::NUM_FEAT_OUT],
  input  gat_pkg::data_t                 a2_i [gat_pkg::NUM_FEAT_OUT],
  output logic [gat_pkg::NODE_IDX_W-1:0] rd_idx_o,
  input  gat_pkg::wh_t                   rd_row_i [gat_pkg::NUM_FEAT_OUT],
  output logic                           coef_push_o,
  output gat_pkg::score_t                coef_data_o,
  input  logic                           coef_full_i
);

  logic                           running;
  logic                           done_r;
  logic                           start;
  logic                           last_idx;
  logic [gat_pkg::NODE_IDX_W-1:0] idx;
  gat_pkg::score_t                s0;
  gat_pkg::score_t                s0_calc;
  gat_pkg::score_t                s_cur;

  assign start    = wh_vld_i && !running && !done_r;
  assign last_idx = (int'(idx) == int'(node_cnt_i) - 1);

  // Row 0 is on the read port while idle, so s0 comes from there
  assign rd_idx_o = running ? idx : '0;

  always_comb begin
    s0_calc = '0;
    s_cur   = s0;
    for (int f = 0; f < gat_pkg::NUM_FEAT_OUT; f++) begin
      s0_calc = s0_calc + gat_pkg::score_t'(a1_i[f]) * gat_pkg::score_t'(rd_row_i[f]);
      s_cur   = s_cur + gat_pkg::score_t'(a2_i[f]) * gat_pkg::score_t'(rd_row_i[f]);
    end
  end

  // LeakyReLU, arithmetic shift floors odd negatives
  assign coef_data_o = (s_cur < 0) ? (s_cur >>> gat_pkg::LEAKY_SHIFT) : s_cur;
  assign coef_push_o = running && !coef_full_i;

  always_ff @(posedge clk) begin
    if (start) begin
      s0 <= s0_calc;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      running <= 1'b0;
      done_r  <= 1'b0;
      idx     <= '0;
    end else begin
      if (start) begin
        running <= 1'b1;
        idx     <= '0;
      end else if (coef_push_o) begin
        if (last_idx) begin
          running <= 1'b0;
          done_r  <= 1'b1;
        end else begin
          idx <= idx + 1'b1;
        end
      end
      // Rearm once the buffer is handed back
      if (done_r && !wh_vld_i) begin
        done_r <= 1'b0;
      end
    end
  end

endmodule

// ==== hdl/gat_layer.sv ====
`timescale 1ns/1ps

module gat_layer (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             param_we_i,
  input  logic [gat_pkg::PARAM_ADDR_W-1:0] param_addr_i,
  input  gat_pkg::data_t                   param_data_i,
  input  logic                             in_req_i,
  input  gat_pkg::data_t                   in_data_i,
  output logic                             in_ack_o,
  output logic                             out_req_o,
  output gat_pkg::feat_t                   out_data_o,
  input  logic                             out_ack_i
);

  gat_pkg::data_t                 w [gat_pkg::NUM_FEAT_IN][gat_pkg::NUM_FEAT_OUT];
  gat_pkg::data_t                 a1 [gat_pkg::NUM_FEAT_OUT];
  gat_pkg::data_t                 a2 [gat_pkg::NUM_FEAT_OUT];
  gat_pkg::wh_t                   coef_rd_row [gat_pkg::NUM_FEAT_OUT];
  gat_pkg::wh_t                   aggr_rd_row [gat_pkg::NUM_FEAT_OUT];
  logic [gat_pkg::NODE_IDX_W-1:0] coef_rd_idx;
  logic [gat_pkg::NODE_IDX_W-1:0] aggr_rd_idx;
  logic [gat_pkg::NODE_CNT_W-1:0] node_cnt;
  logic                           wh_vld;
  logic                           wh_release;

  logic                           coef_push;
  logic                           coef_pop;
  logic                           coef_full;
  logic                           coef_empty;
  gat_pkg::score_t                coef_din;
  gat_pkg::score_t                coef_dout;

  logic                           res_push;
  logic                           res_pop;
  logic                           res_full;
  logic                           res_empty;
  gat_pkg::feat_t                 res_din;
  logic                           ack_wait;

  param_store u_param_store (
    .clk          (clk),
    .rst_n        (rst_n),
    .param_we_i   (param_we_i),
    .param_addr_i (param_addr_i),
    .param_data_i (param_data_i),
    .w_o          (w),
    .a1_o         (a1),
    .a2_o         (a2)
  );

  wh_transform u_wh_transform (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_req_i      (in_req_i),
    .in_data_i     (in_data_i),
    .in_ack_o      (in_ack_o),
    .w_i           (w),
    .wh_vld_o      (wh_vld),
    .node_cnt_o    (node_cnt),
    .wh_release_i  (wh_release),
    .coef_rd_idx_i (coef_rd_idx),
    .coef_rd_row_o (coef_rd_row),
    .aggr_rd_idx_i (aggr_rd_idx),
    .aggr_rd_row_o (aggr_rd_row)
  );

  attn_coef u_attn_coef (
    .clk         (clk),
    .rst_n       (rst_n),
    .wh_vld_i    (wh_vld),
    .node_cnt_i  (node_cnt),
    .a1_i        (a1),
    .a2_i        (a2),
    .rd_idx_o    (coef_rd_idx),
    .rd_row_i    (coef_rd_row),
    .coef_push_o (coef_push),
    .coef_data_o (coef_din),
    .coef_full_i (coef_full)
  );

  sync_fifo #(
    .payload_t (gat_pkg::score_t),
    .DEPTH     (gat_pkg::COEF_FIFO_DEPTH)
  ) u_coef_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .push_i  (coef_push),
    .data_i  (coef_din),
    .full_o  (coef_full),
    .pop_i   (coef_pop),
    .data_o  (coef_dout),
    .empty_o (coef_empty)
  );

  aggregator u_aggregator (
    .clk          (clk),
    .rst_n        (rst_n),
    .node_cnt_i   (node_cnt),
    .coef_pop_o   (coef_pop),
    .coef_data_i  (coef_dout),
    .coef_empty_i (coef_empty),
    .rd_idx_o     (aggr_rd_idx),
    .rd_row_i     (aggr_rd_row),
    .wh_release_o (wh_release),
    .out_push_o   (res_push),
    .out_data_o   (res_din),
    .out_full_i   (res_full)
  );

  sync_fifo #(
    .payload_t (gat_pkg::feat_t),
    .DEPTH     (gat_pkg::OUT_FIFO_DEPTH)
  ) u_out_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .push_i  (res_push),
    .data_i  (res_din),
    .full_o  (res_full),
    .pop_i   (res_pop),
    .data_o  (out_data_o),
    .empty_o (res_empty)
  );

  // Output four-phase handshake on the FIFO head
  assign res_pop = ack_wait && !out_ack_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_req_o <= 1'b0;
      ack_wait  <= 1'b0;
    end else if (!out_req_o && !ack_wait && !res_empty) begin
      out_req_o <= 1'b1;
    end else if (out_req_o && out_ack_i) begin
      out_req_o <= 1'b0;
      ack_wait  <= 1'b1;
    end else if (res_pop) begin
      ack_wait <= 1'b0;
    end
  end

  a_out_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (out_req_o && $past(out_req_o)) |-> $stable(out_data_o)
  );

endmodule

// ==== hdl/gat_pkg.sv ====
package gat_pkg;

  // Subgraph and feature sizes
  localparam int MAX_NODES    = 4;
  localparam int NUM_FEAT_IN  = 4;
  localparam int NUM_FEAT_OUT = 4;
  localparam int DATA_W       = 8;

  // Parameter memory, W row major (row = input feature), then a1 and a2
  localparam int PARAM_DEPTH  = 24;
  localparam int PARAM_ADDR_W = 5;
  localparam int A1_BASE      = 16;
  localparam int A2_BASE      = 20;

  // LeakyReLU slope of 1/8 on negative scores
  localparam int LEAKY_SHIFT  = 3;

  localparam int NODE_CNT_W     = 3;
  localparam int NODE_IDX_W     = 2;
  localparam int FEAT_IN_IDX_W  = $clog2(NUM_FEAT_IN);
  localparam int FEAT_OUT_IDX_W = $clog2(NUM_FEAT_OUT);

  // Exact widths
  // WH is a sum of 4 products of 8x8 bits
  localparam int WH_W    = 18;
  // a1.WH_0 + a2.WH_j, each a sum of 4 products of 8x18 bits
  localparam int SCORE_W = 29;
  // Sum of up to 4 products of 29x18 bits
  localparam int FEAT_W  = 49;

  typedef logic signed [DATA_W-1:0]  data_t;
  typedef logic signed [WH_W-1:0]    wh_t;
  typedef logic signed [SCORE_W-1:0] score_t;
  typedef logic signed [FEAT_W-1:0]  feat_t;

  // One subgraph worth of entries each
  localparam int COEF_FIFO_DEPTH = 4;
  localparam int OUT_FIFO_DEPTH  = 4;

endpackage

// ==== hdl/param_store.sv ====
`timescale 1ns/1ps

module param_store (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             param_we_i,
  input  logic [gat_pkg::PARAM_ADDR_W-1:0] param_addr_i,
  input  gat_pkg::data_t                   param_data_i,
  output gat_pkg::data_t                   w_o [gat_pkg::NUM_FEAT_IN][gat_pkg::NUM_FEAT_OUT],
  output gat_pkg::data_t                   a1_o [gat_pkg::NUM_FEAT_OUT],
  output gat_pkg::data_t                   a2_o [gat_pkg::NUM_FEAT_OUT]
);

  gat_pkg::data_t regs [gat_pkg::PARAM_DEPTH];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < gat_pkg::PARAM_DEPTH; i++) begin
        regs[i] <= '0;
      end
    end else if (param_we_i && (param_addr_i < gat_pkg::PARAM_DEPTH)) begin
      regs[param_addr_i] <= param_data_i;
    end
  end

  // Present W as a matrix and a as two halves
  always_comb begin
    for (int i = 0; i < gat_pkg::NUM_FEAT_IN; i++) begin
      for (int f = 0; f < gat_pkg::NUM_FEAT_OUT; f++) begin
        w_o[i][f] = regs[i * gat_pkg::NUM_FEAT_OUT + f];
      end
    end
    for (int f = 0; f < gat_pkg::NUM_FEAT_OUT; f++) begin
      a1_o[f] = regs[gat_pkg::A1_BASE + f];
      a2_o[f] = regs[gat_pkg::A2_BASE + f];
    end
  end

  a_addr_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    param_we_i |-> (param_addr_i < gat_pkg::PARAM_DEPTH)
  );

endmodule

// ==== hdl/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push_i,
  input  payload_t data_i,
  output logic     full_o,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     empty_o
);

  payload_t                   mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wr_ptr;
  logic [$clog2(DEPTH)-1:0]   rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;
  logic                       do_push;
  logic                       do_pop;

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  assign full_o  = (int'(count) == DEPTH);
  assign empty_o = (count == '0);

  // Head of the queue is visible without a pop
  assign data_o = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= data_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) push_i |-> !full_o);
  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) pop_i |-> !empty_o);

endmodule

// ==== hdl/wh_transform.sv ====
`timescale 1ns/1ps

module wh_transform (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           in_req_i,
  input  gat_pkg::data_t                 in_data_i,
  output logic                           in_ack_o,
  input  gat_pkg::data_t                 w_i [gat_pkg::NUM_FEAT_IN][gat_pkg::NUM_FEAT_OUT],
  output logic                           wh_vld_o,
  output logic [gat_pkg::NODE_CNT_W-1:0] node_cnt_o,
  input  logic                           wh_release_i,
  input  logic [gat_pkg::NODE_IDX_W-1:0] coef_rd_idx_i,
  output gat_pkg::wh_t                   coef_rd_row_o [gat_pkg::NUM_FEAT_OUT],
  input  logic [gat_pkg::NODE_IDX_W-1:0] aggr_rd_idx_i,
  output gat_pkg::wh_t                   aggr_rd_row_o [gat_pkg::NUM_FEAT_OUT]
);

  gat_pkg::wh_t wh_buf [gat_pkg::MAX_NODES][gat_pkg::NUM_FEAT_OUT];
  gat_pkg::wh_t acc [gat_pkg::NUM_FEAT_OUT];
  gat_pkg::wh_t acc_next [gat_pkg::NUM_FEAT_OUT];

  logic                              feat_phase;
  logic [gat_pkg::NODE_IDX_W-1:0]    node_idx;
  logic [gat_pkg::FEAT_IN_IDX_W-1:0] feat_idx;
  logic                              last_row;
  logic                              take;
  logic                              take_cnt;
  logic                              take_feat;
  logic                              row_done;

  // A node count waits until the buffer has been released
  assign take      = in_req_i && !in_ack_o && (feat_phase || !wh_vld_o);
  assign take_cnt  = take && !feat_phase;
  assign take_feat = take && feat_phase;
  assign row_done  = take_feat && (int'(feat_idx) == gat_pkg::NUM_FEAT_IN - 1);

  // Feature times its W row, added to the running row sum
  always_comb begin
    for (int f = 0; f < gat_pkg::NUM_FEAT_OUT; f++) begin
      acc_next[f] = in_data_i * w_i[feat_idx][f];
      if (feat_idx != '0) begin
        acc_next[f] = acc_next[f] + acc[f];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take_feat) begin
      for (int f = 0; f < gat_pkg::NUM_FEAT_OUT; f++) begin
        acc[f] <= acc_next[f];
        if (row_done) begin
          wh_buf[node_idx][f] <= acc_next[f];
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_ack_o   <= 1'b0;
      feat_phase <= 1'b0;
      node_idx   <= '0;
      feat_idx   <= '0;
      node_cnt_o <= '0;
      last_row   <= 1'b0;
      wh_vld_o   <= 1'b0;
    end else begin
      last_row <= 1'b0;
      if (take) begin
        in_ack_o <= 1'b1;
      end else if (!in_req_i) begin
        in_ack_o <= 1'b0;
      end
      if (take_cnt) begin
        node_cnt_o <= in_data_i[gat_pkg::NODE_CNT_W-1:0];
        node_idx   <= '0;
        feat_idx   <= '0;
        feat_phase <= 1'b1;
      end
      if (take_feat) begin
        feat_idx <= feat_idx + 1'b1;
        if (row_done) begin
          feat_idx <= '0;
          node_idx <= node_idx + 1'b1;
          if (int'(node_idx) == int'(node_cnt_o) - 1) begin
            feat_phase <= 1'b0;
            last_row   <= 1'b1;
          end
        end
      end
      if (last_row) begin
        wh_vld_o <= 1'b1;
      end else if (wh_release_i) begin
        wh_vld_o <= 1'b0;
      end
    end
  end

  assign coef_rd_row_o = wh_buf[coef_rd_idx_i];
  assign aggr_rd_row_o = wh_buf[aggr_rd_idx_i];

  a_req_until_ack: assert property (
    @(posedge clk) disable iff (!rst_n) $fell(in_req_i) |-> in_ack_o
  );
  a_cnt_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    take_cnt |-> (in_data_i >= 1 && in_data_i <= gat_pkg::MAX_NODES)
  );

endmodule

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_gat_layer \
  && ./obj_dir/Vtb_gat_layer | tee /dev/stderr | grep -q "RESULT: PASS" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== src.f ====
hdl/gat_pkg.sv
hdl/sync_fifo.sv
hdl/param_store.sv
hdl/wh_transform.sv
hdl/attn_coef.sv
hdl/aggregator.sv
hdl/gat_layer.sv
testbench/tb_clk_gen.sv
testbench/tb_gat_layer.sv

// ==== testbench/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Reset held for five rising edges, released on a falling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (5) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// ==== testbench/tb_gat_layer.sv ====
`timescale 1ns/1ps

module tb_gat_layer;

  localparam int NUM_SUBGRAPHS  = 15;
  localparam int NUM_PARAM_SETS = 6;
  localparam int XFERS_PER_SG   = 1 + gat_pkg::MAX_NODES * gat_pkg::NUM_FEAT_IN
                                  + gat_pkg::NUM_FEAT_OUT;
  localparam int MAX_XFERS      = NUM_SUBGRAPHS * XFERS_PER_SG
                                  + NUM_PARAM_SETS * gat_pkg::PARAM_DEPTH;
  localparam int XFER_BOUND_NS  = 400;

  logic                             clk;
  logic                             rst_n;
  logic                             param_we_i;
  logic [gat_pkg::PARAM_ADDR_W-1:0] param_addr_i;
  gat_pkg::data_t                   param_data_i;
  logic                             in_req_i;
  gat_pkg::data_t                   in_data_i;
  logic                             in_ack_o;
  logic                             out_req_o;
  gat_pkg::feat_t                   out_data_o;
  logic                             out_ack_i;

  int          w_ref [gat_pkg::NUM_FEAT_IN][gat_pkg::NUM_FEAT_OUT];
  int          a1_ref [gat_pkg::NUM_FEAT_OUT];
  int          a2_ref [gat_pkg::NUM_FEAT_OUT];
  int          h_ref [gat_pkg::MAX_NODES][gat_pkg::NUM_FEAT_IN];
  logic [31:0] lcg_state = 32'h0bc6_8550;
  longint      exp_q [$];
  longint      got;
  longint      want;
  int          errors;
  int          checks;
  int          rx_idx;
  int          tests_run;
  int          test_err_start;
  int          ack_delay;
  int          n_nodes;
  bit          slow_ack;

  tb_clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  gat_layer uut (
    .clk          (clk),
    .rst_n        (rst_n),
    .param_we_i   (param_we_i),
    .param_addr_i (param_addr_i),
    .param_data_i (param_data_i),
    .in_req_i     (in_req_i),
    .in_data_i    (in_data_i),
    .in_ack_o     (in_ack_o),
    .out_req_o    (out_req_o),
    .out_data_o   (out_data_o),
    .out_ack_i    (out_ack_i)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int rand_range(int lo, int hi);
    logic [31:0] r;
    r = lcg_next();
    return lo + (int'({1'b0, r[30:8]}) % (hi - lo + 1));
  endfunction

  // Expected new feature f from H, W, a1 and a2
  function automatic longint ref_feature(int n, int f);
    longint wh [gat_pkg::MAX_NODES][gat_pkg::NUM_FEAT_OUT];
    longint s0;
    longint s;
    longint e;
    longint res;
    s0  = 0;
    res = 0;
    for (int j = 0; j < n; j++) begin
      for (int k = 0; k < gat_pkg::NUM_FEAT_OUT; k++) begin
        wh[j][k] = 0;
        for (int i = 0; i < gat_pkg::NUM_FEAT_IN; i++) begin
          wh[j][k] += longint'(h_ref[j][i]) * longint'(w_ref[i][k]);
        end
      end
    end
    for (int k = 0; k < gat_pkg::NUM_FEAT_OUT; k++) begin
      s0 += longint'(a1_ref[k]) * wh[0][k];
    end
    for (int j = 0; j < n; j++) begin
      s = s0;
      for (int k = 0; k < gat_pkg::NUM_FEAT_OUT; k++) begin
        s += longint'(a2_ref[k]) * wh[j][k];
      end
      // Negative slope 1/8, floor division
      e = (s < 0) ? -((-s + 7) / 8) : s;
      res += e * wh[j][f];
    end
    return res;
  endfunction

  task automatic write_param(input int addr, input int value);
    @(negedge clk);
    param_we_i   = 1'b1;
    param_addr_i = addr[gat_pkg::PARAM_ADDR_W-1:0];
    param_data_i = gat_pkg::data_t'(value);
    @(negedge clk);
    param_we_i   = 1'b0;
  endtask

  task automatic load_params();
    for (int i = 0; i < gat_pkg::NUM_FEAT_IN; i++) begin
      for (int f = 0; f < gat_pkg::NUM_FEAT_OUT; f++) begin
        write_param(i * gat_pkg::NUM_FEAT_OUT + f, w_ref[i][f]);
      end
    end
    for (int f = 0; f < gat_pkg::NUM_FEAT_OUT; f++) begin
      write_param(gat_pkg::A1_BASE + f, a1_ref[f]);
      write_param(gat_pkg::A2_BASE + f, a2_ref[f]);
    end
  endtask

  task automatic set_identity(input int a1_val, input int a2_val);
    for (int i = 0; i < gat_pkg::NUM_FEAT_IN; i++) begin
      for (int f = 0; f < gat_pkg::NUM_FEAT_OUT; f++) begin
        w_ref[i][f] = (i == f) ? 1 : 0;
      end
    end
    for (int f = 0; f < gat_pkg::NUM_FEAT_OUT; f++) begin
      a1_ref[f] = a1_val;
      a2_ref[f] = a2_val;
    end
  endtask

  task automatic randomize_params();
    for (int i = 0; i < gat_pkg::NUM_FEAT_IN; i++) begin
      for (int f = 0; f < gat_pkg::NUM_FEAT_OUT; f++) begin
        w_ref[i][f] = rand_range(-128, 127);
      end
    end
    for (int f = 0; f < gat_pkg::NUM_FEAT_OUT; f++) begin
      a1_ref[f] = rand_range(-128, 127);
      a2_ref[f] = rand_range(-128, 127);
    end
  endtask

  task automatic randomize_features(input int n);
    for (int j = 0; j < n; j++) begin
      for (int i = 0; i < gat_pkg::NUM_FEAT_IN; i++) begin
        h_ref[j][i] = rand_range(-128, 127);
      end
    end
  endtask

  // One four-phase transfer on the input channel
  task automatic send_word(input int value);
    @(negedge clk);
    in_data_i = gat_pkg::data_t'(value);
    in_req_i  = 1'b1;
    @(negedge clk);
    while (!in_ack_o) @(negedge clk);
    in_req_i = 1'b0;
    @(negedge clk);
    while (in_ack_o) @(negedge clk);
  endtask

  task automatic send_subgraph(input int n);
    for (int f = 0; f < gat_pkg::NUM_FEAT_OUT; f++) begin
      exp_q.push_back(ref_feature(n, f));
    end
    send_word(n);
    for (int j = 0; j < n; j++) begin
      for (int i = 0; i < gat_pkg::NUM_FEAT_IN; i++) begin
        send_word(h_ref[j][i]);
      end
    end
  endtask

  task automatic drain_results();
    while (exp_q.size() != 0) @(negedge clk);
  endtask

  task automatic finish_test(input string name);
    drain_results();
    tests_run++;
    $display("Test %0d %s: %s, %0d errors", tests_run, name,
             (errors == test_err_start) ? "ok" : "failed", errors - test_err_start);
    test_err_start = errors;
  endtask

  // Output receiver, acks each result and compares it in order
  initial begin
    forever begin
      @(negedge clk);
      if (out_req_o && !out_ack_i) begin
        got = longint'(out_data_o);
        checks++;
        if (exp_q.size() == 0) begin
          $display("Unexpected output word arrived with no result pending");
          errors++;
        end else begin
          want = exp_q.pop_front();
          if (got != want) begin
            $display("[ERROR] out_data_o feature %0d: got %h, expected %h",
                     rx_idx % gat_pkg::NUM_FEAT_OUT, gat_pkg::feat_t'(got),
                     gat_pkg::feat_t'(want));
            errors++;
          end
        end
        rx_idx++;
        ack_delay = slow_ack ? rand_range(0, 15) : rand_range(0, 3);
        repeat (ack_delay) @(negedge clk);
        out_ack_i = 1'b1;
        @(negedge clk);
        while (out_req_o) @(negedge clk);
        out_ack_i = 1'b0;
      end
    end
  end

  initial begin
    #(MAX_XFERS * XFER_BOUND_NS);
    $display("Watchdog expired with %0d results still pending", exp_q.size());
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    param_we_i     = 1'b0;
    param_addr_i   = '0;
    param_data_i   = '0;
    in_req_i       = 1'b0;
    in_data_i      = '0;
    out_ack_i      = 1'b0;
    slow_ack       = 1'b0;
    errors         = 0;
    checks         = 0;
    rx_idx         = 0;
    tests_run      = 0;
    test_err_start = 0;
    wait (rst_n === 1'b1);
    @(negedge clk);

    set_identity(1, 1);
    load_params();
    h_ref[0] = '{3, -1, 5, 2};
    send_subgraph(1);
    finish_test("identity single node");

    randomize_params();
    load_params();
    repeat (3) begin
      randomize_features(gat_pkg::MAX_NODES);
      send_subgraph(gat_pkg::MAX_NODES);
    end
    finish_test("random four-node subgraphs");

    // a2 outweighs a1 so every score ends up negative
    set_identity(1, -2);
    load_params();
    for (int j = 0; j < gat_pkg::MAX_NODES; j++) begin
      for (int i = 0; i < gat_pkg::NUM_FEAT_IN; i++) begin
        h_ref[j][i] = ((j * 5 + i * 3) % 7) + 1;
      end
    end
    send_subgraph(gat_pkg::MAX_NODES);
    finish_test("negative scores");

    randomize_params();
    load_params();
    slow_ack = 1'b1;
    repeat (8) begin
      n_nodes = rand_range(1, gat_pkg::MAX_NODES);
      randomize_features(n_nodes);
      send_subgraph(n_nodes);
    end
    finish_test("back-to-back with slow ack");
    slow_ack = 1'b0;

    // Same H under two parameter sets
    randomize_params();
    load_params();
    randomize_features(3);
    send_subgraph(3);
    drain_results();
    randomize_params();
    load_params();
    send_subgraph(3);
    finish_test("parameter rewrite");

    $display("Tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
